/* Bender.yml */
package:
  name: int_div_iterative

export_include_dirs:
  - verilog

sources:
  # synthesizable divider, package first
  - include_dirs:
      - verilog
    files:
      - verilog/int_div_pkg.sv
      - verilog/int_div_dpath.sv
      - verilog/int_div_ctrl.sv
      - verilog/int_div_iterative.sv

  # testbench, top module int_div_tb
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/int_div_clk_gen.sv
      - bench/int_div_checker.sv
      - bench/int_div_assert.sv
      - bench/int_div_tb.sv

/* bench/int_div_assert.sv */
//----------------------------
// handshake, latency and reset properties bound into the divider top
//----------------------------

`timescale 1ns/1ps

`include "int_div_cfg.svh"

module int_div_assert (
  input logic                    clk,
  input logic                    reset,
  input logic                    req_val,
  input logic                    req_rdy,
  input logic [2*`DIV_WIDTH-1:0] resp_result,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input int_div_pkg::div_state_e state
);

  // failed assertions so far
  int assert_errors;

  initial begin
    assert_errors = 0;
  end

  // a request transfer closes the door until the response leaves
  assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |=> !req_rdy)
    else begin
      assert_errors++;
      $error("request accepted while one is pending");
    end

  assert property (@(posedge clk) disable iff (reset)
    (!req_rdy && !(resp_val && resp_rdy)) |=> !req_rdy)
    else begin
      assert_errors++;
      $error("req_rdy rose before the response transferred");
    end

  // held result must not move
  assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else begin
      assert_errors++;
      $error("response dropped or changed under back-pressure");
    end

  // one quotient bit per cycle with no early exit
  assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |=> (!resp_val) [*`DIV_WIDTH] ##1 resp_val)
    else begin
      assert_errors++;
      $error("resp_val not exactly 32 cycles after the request");
    end

  assert property (@(posedge clk)
    $fell(reset) |-> (req_rdy && !resp_val && state == int_div_pkg::IDLE))
    else begin
      assert_errors++;
      $error("wrong handshake state after reset");
    end

endmodule

bind int_div_iterative int_div_assert int_div_assert_inst (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_result (resp_result),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .state       (int_div_ctrl_inst.state)
);

/* bench/int_div_checker.sv */
//----------------------------
// divider response checker
// reference division per request, compared in order on each response
//----------------------------

`timescale 1ns/1ps

`include "int_div_cfg.svh"

module int_div_checker (
  input  logic                    clk,
  input  logic                    reset,
  input  int_div_pkg::div_fn_e    req_fn,
  input  logic [`DIV_WIDTH-1:0]   req_a,
  input  logic [`DIV_WIDTH-1:0]   req_b,
  input  logic                    req_val,
  input  logic                    req_rdy,
  input  logic [2*`DIV_WIDTH-1:0] resp_result,
  input  logic                    resp_val,
  input  logic                    resp_rdy,
  output int                      error_count,
  output int                      check_count
);

  localparam int W = `DIV_WIDTH;

  // {remainder, quotient} from integer division rules
  function automatic logic [2*W-1:0] expected_result(
    input int_div_pkg::div_fn_e fn,
    input logic [W-1:0]         a,
    input logic [W-1:0]         b
  );
    longint      sa;
    longint      sb;
    longint      q;
    longint      r;
    logic [W-1:0] quot;
    logic [W-1:0] rem;
    if (b == '0) begin
      // all ones magnitude, negated when the dividend is negative
      if (fn == int_div_pkg::DIV_FN_SIGNED && a[W-1]) begin
        quot = W'(1);
      end else begin
        quot = '1;
      end
      rem = a;
    end else if (fn == int_div_pkg::DIV_FN_SIGNED) begin
      // 64-bit math, so min / -1 lands on the min value when truncated
      sa = $signed(a);
      sb = $signed(b);
      q = sa / sb;
      r = sa % sb;
      quot = q[W-1:0];
      rem = r[W-1:0];
    end else begin
      quot = a / b;
      rem = a % b;
    end
    return {rem, quot};
  endfunction

  // outstanding requests, oldest first
  logic [2*W-1:0] exp_q[$];
  logic [W-1:0]   a_q[$];
  logic [W-1:0]   b_q[$];
  logic           signed_q[$];

  logic [2*W-1:0] exp_val;
  logic [W-1:0]   exp_a;
  logic [W-1:0]   exp_b;
  logic           exp_signed;

  // result seen last edge while the consumer stalled
  logic           held_valid;
  logic [2*W-1:0] held_result;

  initial begin
    error_count = 0;
    check_count = 0;
    held_valid = 1'b0;
  end

  always @(posedge clk) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else begin
      if (req_val && req_rdy) begin
        exp_q.push_back(expected_result(req_fn, req_a, req_b));
        a_q.push_back(req_a);
        b_q.push_back(req_b);
        signed_q.push_back(req_fn == int_div_pkg::DIV_FN_SIGNED);
      end
      if (resp_val && held_valid && resp_result !== held_result) begin
        $display("Fail at %0t ns: result changed while held, was %h now %h",
                 $time, held_result, resp_result);
        error_count++;
      end
      held_valid <= resp_val && !resp_rdy;
      held_result <= resp_result;
      if (resp_val && resp_rdy) begin
        check_count++;
        if (exp_q.size() == 0) begin
          $display("a response arrived with no request outstanding, result %h",
                   resp_result);
          error_count++;
        end else begin
          exp_val = exp_q.pop_front();
          exp_a = a_q.pop_front();
          exp_b = b_q.pop_front();
          exp_signed = signed_q.pop_front();
          if (resp_result !== exp_val) begin
            $display("Fail at %0t ns: %s a=%h b=%h expected %h actual %h",
                     $time, exp_signed ? "signed" : "unsigned", exp_a, exp_b,
                     exp_val, resp_result);
            error_count++;
          end
        end
      end
    end
  end

endmodule

/* bench/int_div_clk_gen.sv */
//----------------------------
// testbench clock, 8 ns period
// reset held high for the first 8 cycles
//----------------------------

`timescale 1ns/1ps

module int_div_clk_gen #(
  parameter int HALF_PERIOD_NS = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

/* bench/int_div_tb.sv */
//----------------------------
// divider testbench top, directed and random divisions
// last phase randomizes resp_rdy, watchdog bounds the run
//----------------------------

`timescale 1ns/1ps

`include "int_div_cfg.svh"

module int_div_tb;

  localparam int W = `DIV_WIDTH;
  localparam int N_DIRECTED = 18;
  localparam int N_RANDOM = 80;
  localparam int N_BACKPRESSURE = 60;
  localparam int NUM_TESTS = N_DIRECTED + N_RANDOM + N_BACKPRESSURE;
  localparam int CLK_PERIOD_NS = 8;
  localparam int RESET_CYCLES = 8;
  // generous 48 cycles per division
  localparam int TIMEOUT_NS = NUM_TESTS * 48 * CLK_PERIOD_NS + RESET_CYCLES * CLK_PERIOD_NS;
  localparam logic [31:0] SEED = 32'h6ef3d5a8;
  localparam logic [W-1:0] MIN_NEG = {1'b1, {(W - 1){1'b0}}};

  logic                 clk;
  logic                 reset;
  int_div_pkg::div_fn_e req_fn;
  logic [W-1:0]         req_a;
  logic [W-1:0]         req_b;
  logic                 req_val;
  logic                 req_rdy;
  logic [2*W-1:0]       resp_result;
  logic                 resp_val;
  logic                 resp_rdy;

  int   sent_count;
  int   checker_errors;
  int   check_count;
  int   assert_errors;
  logic bp_mode;

  assign assert_errors = int_div_iterative_inst.int_div_assert_inst.assert_errors;

  int_div_clk_gen #(
    .HALF_PERIOD_NS (CLK_PERIOD_NS / 2),
    .RESET_CYCLES   (RESET_CYCLES)
  ) int_div_clk_gen_inst (
    .clk   (clk),
    .reset (reset)
  );

  int_div_iterative int_div_iterative_inst (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  int_div_checker int_div_checker_inst (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .error_count (checker_errors),
    .check_count (check_count)
  );

  // called on a falling edge and returns on the falling edge after the transfer
  task automatic send_request(
    input int_div_pkg::div_fn_e fn,
    input logic [W-1:0]         a,
    input logic [W-1:0]         b
  );
    req_fn = fn;
    req_a = a;
    req_b = b;
    req_val = 1'b1;
    // req_rdy only moves on rising edges so it is steady here
    while (!req_rdy) @(negedge clk);
    @(negedge clk);
    req_val = 1'b0;
    sent_count++;
  endtask

  // mix of full-range and small divisors with the sign flipped at random
  task automatic send_random(input int_div_pkg::div_fn_e fn);
    logic [W-1:0] a;
    logic [W-1:0] b;
    a = $urandom;
    if ($urandom % 3 == 0) begin
      b = $urandom;
    end else begin
      b = $urandom_range(255, 1);
      if (fn == int_div_pkg::DIV_FN_SIGNED && $urandom % 2 == 1) begin
        b = -b;
      end
    end
    send_request(fn, a, b);
  endtask

  // consumer is always ready outside the back-pressure phase
  task automatic drive_resp_rdy();
    forever begin
      @(negedge clk);
      resp_rdy = bp_mode ? 1'($urandom) : 1'b1;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    req_fn = int_div_pkg::DIV_FN_UNSIGNED;
    req_a = '0;
    req_b = '0;
    req_val = 1'b0;
    resp_rdy = 1'b1;
    bp_mode = 1'b0;
    sent_count = 0;
    fork
      drive_resp_rdy();
    join_none
    wait (reset === 1'b1);
    wait (reset === 1'b0);

    // unsigned directed
    send_request(int_div_pkg::DIV_FN_UNSIGNED, 32'd100, 32'd7);
    send_request(int_div_pkg::DIV_FN_UNSIGNED, 32'hffffffff, 32'd1);
    send_request(int_div_pkg::DIV_FN_UNSIGNED, 32'hffffffff, 32'hffffffff);
    send_request(int_div_pkg::DIV_FN_UNSIGNED, 32'd5, 32'd9);
    send_request(int_div_pkg::DIV_FN_UNSIGNED, 32'h12345678, 32'd0);
    send_request(int_div_pkg::DIV_FN_UNSIGNED, 32'd0, 32'd3);
    // signed division over all four sign pairs
    send_request(int_div_pkg::DIV_FN_SIGNED, 32'd100, 32'd7);
    send_request(int_div_pkg::DIV_FN_SIGNED, -32'sd100, 32'd7);
    send_request(int_div_pkg::DIV_FN_SIGNED, 32'd100, -32'sd7);
    send_request(int_div_pkg::DIV_FN_SIGNED, -32'sd100, -32'sd7);
    // overflow, divide by zero, by one, small over large
    send_request(int_div_pkg::DIV_FN_SIGNED, MIN_NEG, 32'hffffffff);
    send_request(int_div_pkg::DIV_FN_SIGNED, -32'sd37, 32'd0);
    send_request(int_div_pkg::DIV_FN_SIGNED, 32'd37, 32'd0);
    send_request(int_div_pkg::DIV_FN_SIGNED, -32'sd5, 32'd1);
    send_request(int_div_pkg::DIV_FN_SIGNED, 32'd3, -32'sd8);
    send_request(int_div_pkg::DIV_FN_SIGNED, MIN_NEG, 32'd1);
    send_request(int_div_pkg::DIV_FN_SIGNED, 32'h7fffffff, 32'hffffffff);
    send_request(int_div_pkg::DIV_FN_SIGNED, MIN_NEG, MIN_NEG);

    for (int i = 0; i < N_RANDOM / 2; i++) begin
      send_random(int_div_pkg::DIV_FN_UNSIGNED);
    end
    for (int i = 0; i < N_RANDOM / 2; i++) begin
      send_random(int_div_pkg::DIV_FN_SIGNED);
    end

    // random stalls on the response side
    bp_mode = 1'b1;
    for (int i = 0; i < N_BACKPRESSURE; i++) begin
      send_random(int_div_pkg::div_fn_e'($urandom % 2));
    end

    wait (check_count == sent_count);
    repeat (4) @(negedge clk);
    $display("responses checked %0d of %0d, checker errors %0d, assertion errors %0d",
             check_count, sent_count, checker_errors, assert_errors);
    if (checker_errors + assert_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("the run timed out after %0d ns with %0d of %0d responses seen",
             TIMEOUT_NS, check_count, NUM_TESTS);
    $display("tests failed");
    $finish;
  end

endmodule

/* int_div_iterative.f */
+incdir+verilog
verilog/int_div_pkg.sv
verilog/int_div_dpath.sv
verilog/int_div_ctrl.sv
verilog/int_div_iterative.sv
bench/int_div_clk_gen.sv
bench/int_div_checker.sv
bench/int_div_assert.sv
bench/int_div_tb.sv

/* verilog/int_div_cfg.svh */
//----------------------------
// width settings for the iterative divider
// include wherever operand or counter widths are needed
//----------------------------

`ifndef INT_DIV_CFG_SVH
`define INT_DIV_CFG_SVH

// operand width, dividend and divisor
`define DIV_WIDTH 32

// iteration counter, counts DIV_WIDTH steps down to zero
`define DIV_CNT_W 5

`endif

/* verilog/int_div_ctrl.sv */
//----------------------------
// divider control, idle/calc/done FSM
// owns both val/rdy handshakes, drives load and step
//----------------------------

`timescale 1ns/1ps

module int_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  input  logic count_zero,
  output logic req_rdy,
  output logic resp_val,
  output logic load,
  output logic step
);

  int_div_pkg::div_state_e state;
  int_div_pkg::div_state_e state_next;

  logic req_xfer;
  logic resp_xfer;

  //----------------------------
  // handshake decode
  //----------------------------

  // a transfer is valid and ready on the same edge
  assign req_xfer = req_val & req_rdy;
  assign resp_xfer = resp_val & resp_rdy;

  //----------------------------
  // state register
  //----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= int_div_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  //----------------------------
  // next state
  //----------------------------

  always_comb begin
    state_next = state;
    case (state)
      int_div_pkg::IDLE: begin
        // operands are captured on this same edge
        if (req_xfer) begin
          state_next = int_div_pkg::CALC;
        end
      end
      int_div_pkg::CALC: begin
        // count_zero marks the last of the steps
        if (count_zero) begin
          state_next = int_div_pkg::DONE;
        end
      end
      int_div_pkg::DONE: begin
        // hold the result under back-pressure
        if (resp_xfer) begin
          state_next = int_div_pkg::IDLE;
        end
      end
      default: begin
        state_next = int_div_pkg::IDLE;
      end
    endcase
  end

  //----------------------------
  // outputs, decoded from state
  //----------------------------

  // only accept work when nothing is in flight
  assign req_rdy = (state == int_div_pkg::IDLE);

  assign resp_val = (state == int_div_pkg::DONE);

  // datapath loads exactly on the request edge
  assign load = req_xfer;

  // one iteration per cycle for the whole of CALC
  assign step = (state == int_div_pkg::CALC);

endmodule

/* verilog/int_div_dpath.sv */
//----------------------------
// divider datapath, restoring shift-subtract on magnitudes
// load captures operands, step runs one iteration
//----------------------------

`timescale 1ns/1ps

`include "int_div_cfg.svh"

module int_div_dpath (
  input  logic                       clk,
  input  logic                       reset,
  input  int_div_pkg::div_fn_e       req_fn,
  input  logic [`DIV_WIDTH-1:0]      req_a,
  input  logic [`DIV_WIDTH-1:0]      req_b,
  input  logic                       load,
  input  logic                       step,
  output logic [2*`DIV_WIDTH-1:0]    resp_result,
  output logic                       count_zero
);

  localparam int W = `DIV_WIDTH;
  // remainder/quotient register, one extra bit catches the borrow
  localparam int RW = 2 * W + 1;
  // counter starts at W-1 and ends the run at zero
  localparam logic [`DIV_CNT_W-1:0] CNT_INIT = `DIV_CNT_W'(W - 1);
  localparam logic [`DIV_CNT_W-1:0] CNT_ONE = `DIV_CNT_W'(1);

  // two's complement negate when neg is set
  function automatic logic [W-1:0] cond_negate(input logic [W-1:0] value, input logic neg);
    cond_negate = neg ? -value : value;
  endfunction

  //----------------------------
  // operand conditioning
  //----------------------------

  logic          signed_op;
  logic          a_neg;
  logic          b_neg;
  logic [W-1:0]  a_mag;
  logic [W-1:0]  b_mag;

  assign signed_op = (req_fn == int_div_pkg::DIV_FN_SIGNED);
  // sign bits only count for signed requests
  assign a_neg = signed_op & req_a[W-1];
  assign b_neg = signed_op & req_b[W-1];
  assign a_mag = cond_negate(req_a, a_neg);
  assign b_mag = cond_negate(req_b, b_neg);

  //----------------------------
  // shift-subtract step
  //----------------------------

  // rq_reg holds partial remainder above, quotient bits below
  logic [RW-1:0] rq_reg;
  // divisor magnitude sits in the upper half
  logic [RW-1:0] dvsr_reg;
  logic          q_neg;
  logic          r_neg;
  logic [RW-1:0] shifted;
  logic [RW-1:0] diff;
  logic [RW-1:0] rq_next;

  assign shifted = rq_reg << 1;
  assign diff = shifted - dvsr_reg;

  // negative difference means the divisor did not fit, so restore
  // otherwise keep the difference and shift in a one
  assign rq_next = diff[RW-1] ? {shifted[RW-1:1], 1'b0} : {diff[RW-1:1], 1'b1};

  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg   <= {{(W + 1){1'b0}}, a_mag};
      dvsr_reg <= {1'b0, b_mag, {W{1'b0}}};
      // quotient is negative when exactly one operand is
      q_neg    <= a_neg ^ b_neg;
      // remainder follows the dividend
      r_neg    <= a_neg;
    end else if (step) begin
      rq_reg <= rq_next;
    end
  end

  //----------------------------
  // iteration counter
  //----------------------------

  logic [`DIV_CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= CNT_INIT;
    end else if (step) begin
      // wraps on the last step, harmless since control leaves CALC
      count <= count - CNT_ONE;
    end
  end

  // high during the final step
  assign count_zero = (count == '0);

  //----------------------------
  // sign fixup
  //----------------------------

  logic [W-1:0] quot_mag;
  logic [W-1:0] rem_mag;

  assign quot_mag = rq_reg[W-1:0];
  // remainder always fits W bits once the run is done
  assign rem_mag = rq_reg[2*W-1:W];

  // remainder high, quotient low
  assign resp_result = {cond_negate(rem_mag, r_neg), cond_negate(quot_mag, q_neg)};

endmodule

/* verilog/int_div_iterative.sv */
//----------------------------
// iterative 32-bit integer divider, top level
// val/rdy request in, {remainder, quotient} response out
//----------------------------

`timescale 1ns/1ps

`include "int_div_cfg.svh"

module int_div_iterative (
  input  logic                    clk,
  input  logic                    reset,
  // request side
  input  int_div_pkg::div_fn_e    req_fn,
  input  logic [`DIV_WIDTH-1:0]   req_a,
  input  logic [`DIV_WIDTH-1:0]   req_b,
  input  logic                    req_val,
  output logic                    req_rdy,
  // response side
  output logic [2*`DIV_WIDTH-1:0] resp_result,
  output logic                    resp_val,
  input  logic                    resp_rdy
);

  // control to datapath
  logic load;
  logic step;
  // datapath back to control
  logic count_zero;

  // fsm and handshake
  int_div_ctrl int_div_ctrl_inst (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .resp_rdy   (resp_rdy),
    .count_zero (count_zero),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .load       (load),
    .step       (step)
  );

  // operand registers, shift-subtract, sign fixup
  int_div_dpath int_div_dpath_inst (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .load        (load),
    .step        (step),
    .resp_result (resp_result),
    .count_zero  (count_zero)
  );

endmodule

/* verilog/int_div_pkg.sv */
//----------------------------
// shared types for the divider
// referenced by scoped name only
//----------------------------

package int_div_pkg;

  // request function, one bit on the request port
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // control FSM state
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    // one quotient bit per cycle
    CALC = 2'd1,
    // result held until the response transfers
    DONE = 2'd2
  } div_state_e;

endpackage
